// ==== bench/fetch_input.txt ====
# enable busy jump ctx_switch jump_target switch_target sys_reset
# busy 2 means a random stall, targets in hex
1 0 0 0 00000000 00000000 0
1 0 0 0 00000000 00000000 0
1 0 0 0 00000000 00000000 0
1 1 0 0 00000000 00000000 0
1 1 0 0 00000000 00000000 0
1 0 0 0 00000000 00000000 0
0 0 0 0 00000000 00000000 0
0 0 0 0 00000000 00000000 0
0 0 0 0 00000000 00000000 0
0 0 0 0 00000000 00000000 0
1 0 0 0 00000000 00000000 0
1 0 0 0 00000000 00000000 0
1 0 1 0 00000100 00000000 0
1 2 0 0 00000000 00000000 0
1 2 0 0 00000000 00000000 0
1 2 0 0 00000000 00000000 0
1 0 1 1 00000200 00000300 0
0 2 0 0 00000000 00000000 0
0 2 0 0 00000000 00000000 0
1 0 0 0 00000000 00000000 0
1 0 0 0 00000000 00000000 0
1 0 0 0 00000000 00000000 1
1 2 0 0 00000000 00000000 0
1 2 0 0 00000000 00000000 0
0 0 1 0 00000440 00000000 0

// ==== bench/tb_fetch_checks.svh ====
// Fetch unit checks
`ifndef TB_FETCH_CHECKS_SVH
`define TB_FETCH_CHECKS_SVH

// Word the memory model holds at an address
function automatic instr_t mem_word(input addr_t addr);
    return instr_t'(addr) ^ MEM_PATTERN;
endfunction

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
        $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        $display("TESTS FAILED");
        $fatal(1);
    end
endtask

task automatic check_instr(input string name, input instr_t got, input instr_t exp);
    if (got !== exp) begin
        $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        $display("TESTS FAILED");
        $fatal(1);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        $display("TESTS FAILED");
        $fatal(1);
    end
endtask

// Reference model, called at each falling edge
task automatic check_outputs();
    logic delivered;
    // Redirects seen at the last rising edge, system reset first
    if (saw_sys) begin
        exp_pc  = START_ADDRESS;
        pending = 1'b1;
        check_addr("pc_o", pc_o, START_ADDRESS);
        check_instr("instruction_o", instruction_o, INSTR_NOP);
        check_bit("valid_o", valid_o, 1'b0);
        check_addr("instruction_address_o", instruction_address_o, START_ADDRESS);
    end else if (saw_ctx || saw_jump) begin
        exp_pc   = saw_ctx ? saw_ctx_target : saw_jump_target;
        pending  = 1'b1;
        at_start = 1'b0;
        // Fetch restarts at the selected target right after the redirect edge
        check_addr("instruction_address_o", instruction_address_o, exp_pc);
    end
    delivered = took_en && valid_o;
    if (delivered) begin
        check_addr("pc_o", pc_o, exp_pc);
        check_instr("instruction_o", instruction_o, mem_word(exp_pc));
        check_bit("jumping_o", jumping_o, 1'b0);
        exp_pc      = exp_pc + ADDR_STEP;
        pending     = 1'b0;
        at_start    = 1'b0;
        n_delivered = n_delivered + 1;
    end else if (pending) begin
        check_bit("jumping_o", jumping_o, 1'b1);
    end
    if (at_start) begin
        check_addr("pc_o", pc_o, START_ADDRESS);
        check_instr("instruction_o", instruction_o, INSTR_NOP);
        check_bit("jumping_o", jumping_o, 1'b1);
    end
    // Outputs frozen after an edge without enable
    if (have_prev && !took_en && !saw_sys) begin
        check_addr("pc_o", pc_o, prev_pc);
        check_instr("instruction_o", instruction_o, prev_instr);
        check_bit("valid_o", valid_o, prev_valid);
    end
    prev_pc    = pc_o;
    prev_instr = instruction_o;
    prev_valid = valid_o;
    have_prev  = 1'b1;
endtask

`endif

// ==== bench/tb_fetch_unit.sv ====
// Fetch unit testbench
`timescale 1ns/100ps

module tb_fetch_unit;
    import fetch_addr_pkg::*;
    import fetch_instr_pkg::*;

    localparam int     PERIOD       = 20;
    localparam int     DRAIN_CYCLES = 12;
    localparam instr_t MEM_PATTERN  = 32'h5a3c_96e1;

    logic   clk;
    logic   reset_n;
    logic   sys_reset_i;
    logic   enable_i;
    logic   jump_i;
    logic   ctx_switch_i;
    addr_t  jump_target_i;
    addr_t  ctx_switch_target_i;
    logic   busy_i;
    instr_t instruction_data_i;
    addr_t  instruction_address_o;
    addr_t  pc_o;
    instr_t instruction_o;
    logic   valid_o;
    logic   jumping_o;

    // Stimulus table from the data file
    logic [31:0] f_en[$], f_busy[$], f_jump[$], f_ctx[$];
    logic [31:0] f_jt[$], f_ct[$], f_sys[$];
    int          n_lines = 0;

    // Events seen at the last rising edge
    logic  running = 1'b0;
    logic  took_en = 1'b0;
    logic  saw_sys = 1'b0;
    logic  saw_jump = 1'b0;
    logic  saw_ctx = 1'b0;
    addr_t saw_jump_target;
    addr_t saw_ctx_target;

    // Reference model state
    addr_t  exp_pc = START_ADDRESS;
    logic   pending = 1'b1;
    logic   at_start = 1'b1;
    logic   have_prev = 1'b0;
    addr_t  prev_pc;
    instr_t prev_instr;
    logic   prev_valid;
    int     n_delivered = 0;

    `include "tb_fetch_checks.svh"

    fetch_unit uut (
        .clk                   (clk),
        .reset_n               (reset_n),
        .sys_reset_i           (sys_reset_i),
        .enable_i              (enable_i),
        .jump_i                (jump_i),
        .ctx_switch_i          (ctx_switch_i),
        .jump_target_i         (jump_target_i),
        .ctx_switch_target_i   (ctx_switch_target_i),
        .busy_i                (busy_i),
        .instruction_data_i    (instruction_data_i),
        .instruction_address_o (instruction_address_o),
        .pc_o                  (pc_o),
        .instruction_o         (instruction_o),
        .valid_o               (valid_o),
        .jumping_o             (jumping_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Memory answers one cycle late, nothing new while busy
    always @(posedge clk) begin
        if (!busy_i) begin
            instruction_data_i <= mem_word(instruction_address_o);
        end
        if (running) begin
            took_en         = enable_i;
            saw_sys         = sys_reset_i;
            saw_jump        = jump_i;
            saw_ctx         = ctx_switch_i;
            saw_jump_target = jump_target_i;
            saw_ctx_target  = ctx_switch_target_i;
        end
    end

    // Run limit grows with the stimulus length
    initial begin
        wait (n_lines > 0);
        #((n_lines + DRAIN_CYCLES + 4) * 20 * PERIOD);
        $display("Timeout: the stimulus did not finish in time");
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        int    fd;
        int    cnt;
        string line;
        logic [31:0] v[7];
        void'($urandom(32'ha75bfbaf));
        reset_n             = 1'b0;
        sys_reset_i         = 1'b0;
        enable_i            = 1'b0;
        jump_i              = 1'b0;
        ctx_switch_i        = 1'b0;
        jump_target_i       = '0;
        ctx_switch_target_i = '0;
        busy_i              = 1'b0;
        instruction_data_i  = '0;
        fd = $fopen("bench/fetch_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            $display("TESTS FAILED");
            $fatal(1);
        end
        while ($fgets(line, fd) != 0) begin
            // Skip comments and blank lines
            if (line.len() > 1 && line[0] != "#") begin
                cnt = $sscanf(line, "%h %h %h %h %h %h %h",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
                if (cnt != 7) begin
                    $display("Malformed stimulus line: %s", line);
                    $display("TESTS FAILED");
                    $fatal(1);
                end
                f_en.push_back(v[0]);
                f_busy.push_back(v[1]);
                f_jump.push_back(v[2]);
                f_ctx.push_back(v[3]);
                f_jt.push_back(v[4]);
                f_ct.push_back(v[5]);
                f_sys.push_back(v[6]);
            end
        end
        $fclose(fd);
        n_lines = f_en.size();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n  = 1'b1;
        enable_i = 1'b1;
        running  = 1'b1;
        for (int i = 0; i < n_lines + DRAIN_CYCLES; i++) begin
            @(negedge clk);
            check_outputs();
            if (i < n_lines) begin
                enable_i            = f_en[i][0];
                // Busy value 2 asks for a random stall
                busy_i              = (f_busy[i] == 2) ? ($urandom % 3 == 0) : f_busy[i][0];
                jump_i              = f_jump[i][0];
                ctx_switch_i        = f_ctx[i][0];
                jump_target_i       = f_jt[i];
                ctx_switch_target_i = f_ct[i];
                sys_reset_i         = f_sys[i][0];
            end else begin
                enable_i     = 1'b1;
                busy_i       = 1'b0;
                jump_i       = 1'b0;
                ctx_switch_i = 1'b0;
                sys_reset_i  = 1'b0;
            end
        end
        if (n_delivered < 8) begin
            $display("Too few instructions were delivered: %0d", n_delivered);
            $display("TESTS FAILED");
            $fatal(1);
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== fetch_unit.f ====
+incdir+bench
source/fetch_addr_pkg.sv
source/fetch_instr_pkg.sv
source/redirect_ctrl.sv
source/instr_queue.sv
source/fetch_addr_gen.sv
source/decode_issue.sv
source/fetch_unit.sv
bench/tb_fetch_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f fetch_unit.f \
    --top-module tb_fetch_unit

./obj_dir/Vtb_fetch_unit 2>&1 | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi

// ==== source/decode_issue.sv ====
// Decode stage output registers
`timescale 1ns/100ps

module decode_issue (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    sys_reset_i,
    input  logic                    enable_i,
    input  logic                    redirect_i,
    input  logic                    confirmed_r_i,
    input  fetch_addr_pkg::addr_t   pc_target_i,
    input  logic                    fetch_valid_i,
    input  logic                    queue_valid_i,
    input  fetch_instr_pkg::instr_t queue_data_i,
    input  fetch_instr_pkg::instr_t instruction_data_i,
    output logic                    accept_o,
    output fetch_addr_pkg::addr_t   pc_o,
    output fetch_instr_pkg::instr_t instruction_o,
    output logic                    valid_o,
    output logic                    jumping_o
);
    import fetch_addr_pkg::*;
    import fetch_instr_pkg::*;

    logic   source_valid;
    instr_t next_instr;

    // Queued words are older than the one on the bus
    assign next_instr = queue_valid_i ? queue_data_i : instruction_data_i;

    // Nothing from the old stream passes in the redirect cycle
    assign source_valid = (fetch_valid_i || queue_valid_i) && !redirect_i;
    assign accept_o     = enable_i && source_valid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o       <= 1'b0;
            instruction_o <= INSTR_NOP;
        end else if (sys_reset_i) begin
            valid_o       <= 1'b0;
            instruction_o <= INSTR_NOP;
        end else if (enable_i) begin
            valid_o <= source_valid;
            if (source_valid) begin
                instruction_o <= next_instr;
            end
        end
    end

    // Target first, then step per accepted instruction
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_o <= START_ADDRESS;
        end else if (sys_reset_i) begin
            pc_o <= START_ADDRESS;
        end else if (enable_i) begin
            if (confirmed_r_i) begin
                pc_o <= pc_target_i;
            end else if (source_valid) begin
                pc_o <= pc_o + ADDR_STEP;
            end
        end
    end

    // Tells decode the stream is switching
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumping_o <= 1'b1;
        end else if (sys_reset_i) begin
            jumping_o <= 1'b1;
        end else if (redirect_i) begin
            jumping_o <= 1'b1;
        end else if (accept_o) begin
            jumping_o <= 1'b0;
        end
    end

endmodule

// ==== source/fetch_addr_gen.sv ====
// Fetch address generator
`timescale 1ns/100ps

module fetch_addr_gen (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  sys_reset_i,
    input  logic                  enable_i,
    input  logic                  busy_i,
    input  logic                  redirect_i,
    input  fetch_addr_pkg::addr_t redirect_target_i,
    input  logic                  jumped_r_i,
    input  logic                  queue_valid_i,
    input  logic                  queue_space_i,
    input  logic                  almost_full_i,
    output logic                  push_o,
    output logic                  pop_o,
    output logic                  fetch_valid_o,
    output fetch_addr_pkg::addr_t instruction_address_o
);
    import fetch_addr_pkg::*;

    logic  busy_r;
    logic  hold;
    logic  hold_r;
    addr_t fetch_addr;

    // Decode drains the queue whenever it is enabled
    assign pop_o = enable_i;

    // Busy memory gave no answer, start-up counts as busy
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_r <= 1'b1;
        end else if (sys_reset_i) begin
            busy_r <= 1'b1;
        end else begin
            busy_r <= busy_i;
        end
    end

    // Word on the bus is usable unless a redirect made it stale
    assign fetch_valid_o = !busy_r && !jumped_r_i;

    // Queue the word unless decode takes it straight from memory
    assign push_o = fetch_valid_o && (!pop_o || queue_valid_i) && queue_space_i;

    // Hold the address on a busy memory
    // or when the word now arriving fills the queue
    // or when there is no room at all
    assign hold = busy_i
               || (!pop_o && ((almost_full_i && fetch_valid_o) || !queue_space_i));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hold_r <= 1'b0;
        end else if (sys_reset_i) begin
            hold_r <= 1'b0;
        end else begin
            hold_r <= hold;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fetch_addr <= START_ADDRESS;
        end else if (sys_reset_i) begin
            fetch_addr <= START_ADDRESS;
        end else if (redirect_i) begin
            fetch_addr <= redirect_target_i;
        end else if (!hold || (hold_r && push_o)) begin
            // Held request finally landed in the queue
            fetch_addr <= fetch_addr + ADDR_STEP;
        end
    end

    assign instruction_address_o = {fetch_addr[ADDR_W-1:2], 2'b00};

    // Redirect targets keep the address on word boundaries
    a_word_aligned : assert property (
        @(posedge clk) disable iff (!reset_n)
        fetch_addr[1:0] == 2'b00
    );

endmodule

// ==== source/fetch_addr_pkg.sv ====
// Fetch address definitions
package fetch_addr_pkg;

    // Byte address width of the instruction bus
    localparam int ADDR_W = 32;

    // Byte address as seen by memory and decode
    typedef logic [ADDR_W-1:0] addr_t;

    // Program counter after power-on or system reset
    localparam addr_t START_ADDRESS = '0;

    // Distance between two consecutive 32-bit instructions
    localparam addr_t ADDR_STEP = addr_t'(4);

endpackage

// ==== source/fetch_instr_pkg.sv ====
// Instruction word definitions
package fetch_instr_pkg;

    // One uncompressed RISC-V instruction
    typedef logic [31:0] instr_t;

    // addi x0, x0, 0
    localparam instr_t INSTR_NOP = 32'h0000_0013;

    // Entries in the instruction queue
    localparam int IQUEUE_DEPTH = 2;

endpackage

// ==== source/fetch_unit.sv ====
// Instruction fetch unit
`timescale 1ns/100ps

module fetch_unit (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  sys_reset_i,
    input  logic                  enable_i,
    // Redirect requests
    input  logic                  jump_i,
    input  logic                  ctx_switch_i,
    input  fetch_addr_pkg::addr_t jump_target_i,
    input  fetch_addr_pkg::addr_t ctx_switch_target_i,
    // Instruction memory
    input  logic                  busy_i,
    input  fetch_instr_pkg::instr_t instruction_data_i,
    output fetch_addr_pkg::addr_t instruction_address_o,
    // Towards decode
    output fetch_addr_pkg::addr_t pc_o,
    output fetch_instr_pkg::instr_t instruction_o,
    output logic                  valid_o,
    output logic                  jumping_o
);
    import fetch_addr_pkg::*;
    import fetch_instr_pkg::*;

    // Redirect control
    logic   redirect;
    addr_t  redirect_target;
    addr_t  pc_target;
    logic   confirmed_r;
    logic   jumped_r;

    // Queue side
    logic   push;
    logic   pop;
    logic   queue_valid;
    instr_t queue_data;
    logic   space;
    logic   almost_full;

    // Fetch status and decode acceptance
    logic   fetch_valid;
    logic   accept;

    redirect_ctrl u_redirect_ctrl (
        .clk                 (clk),
        .reset_n             (reset_n),
        .sys_reset_i         (sys_reset_i),
        .jump_i              (jump_i),
        .ctx_switch_i        (ctx_switch_i),
        .jump_target_i       (jump_target_i),
        .ctx_switch_target_i (ctx_switch_target_i),
        .accept_i            (accept),
        .redirect_o          (redirect),
        .redirect_target_o   (redirect_target),
        .confirmed_r_o       (confirmed_r),
        .jumped_r_o          (jumped_r),
        .pc_target_o         (pc_target)
    );

    fetch_addr_gen u_fetch_addr_gen (
        .clk                   (clk),
        .reset_n               (reset_n),
        .sys_reset_i           (sys_reset_i),
        .enable_i              (enable_i),
        .busy_i                (busy_i),
        .redirect_i            (redirect),
        .redirect_target_i     (redirect_target),
        .jumped_r_i            (jumped_r),
        .queue_valid_i         (queue_valid),
        .queue_space_i         (space),
        .almost_full_i         (almost_full),
        .push_o                (push),
        .pop_o                 (pop),
        .fetch_valid_o         (fetch_valid),
        .instruction_address_o (instruction_address_o)
    );

    // Queue is emptied by any redirect or by system reset
    instr_queue u_instr_queue (
        .clk           (clk),
        .reset_n       (reset_n),
        .flush_i       (redirect || sys_reset_i),
        .push_i        (push),
        .data_i        (instruction_data_i),
        .space_o       (space),
        .pop_i         (pop),
        .valid_o       (queue_valid),
        .data_o        (queue_data),
        .almost_full_o (almost_full)
    );

    decode_issue u_decode_issue (
        .clk                (clk),
        .reset_n            (reset_n),
        .sys_reset_i        (sys_reset_i),
        .enable_i           (enable_i),
        .redirect_i         (redirect),
        .confirmed_r_i      (confirmed_r),
        .pc_target_i        (pc_target),
        .fetch_valid_i      (fetch_valid),
        .queue_valid_i      (queue_valid),
        .queue_data_i       (queue_data),
        .instruction_data_i (instruction_data_i),
        .accept_o           (accept),
        .pc_o               (pc_o),
        .instruction_o      (instruction_o),
        .valid_o            (valid_o),
        .jumping_o          (jumping_o)
    );

endmodule

// ==== source/instr_queue.sv ====
// Instruction ring buffer
`timescale 1ns/100ps

module instr_queue (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    flush_i,
    input  logic                    push_i,
    input  fetch_instr_pkg::instr_t data_i,
    output logic                    space_o,
    input  logic                    pop_i,
    output logic                    valid_o,
    output fetch_instr_pkg::instr_t data_o,
    output logic                    almost_full_o
);
    import fetch_instr_pkg::*;

    // Storage, no reset needed
    instr_t mem [IQUEUE_DEPTH];

    logic [$clog2(IQUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(IQUEUE_DEPTH)-1:0] rd_ptr;
    logic [$clog2(IQUEUE_DEPTH+1)-1:0] count;

    logic do_push;
    logic do_pop;

    // Flushed entries are never shown
    assign valid_o = (count != '0) && !flush_i;
    assign data_o  = mem[rd_ptr];

    // A read frees a slot for a write in the same cycle
    assign do_pop  = pop_i && valid_o;
    assign space_o = (count != IQUEUE_DEPTH) || do_pop;
    assign do_push = push_i && space_o && !flush_i;

    // One slot left
    assign almost_full_o = (count == IQUEUE_DEPTH - 1);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at the last entry
            if (do_push) begin
                if (wr_ptr == IQUEUE_DEPTH - 1) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == IQUEUE_DEPTH - 1) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // Occupancy follows the net transfer
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Fetch side must stop pushing once the queue is full
    a_no_push_full : assert property (
        @(posedge clk) disable iff (!reset_n)
        (push_i && !flush_i) |-> space_o
    );

    // A read only hits a written entry
    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (!reset_n)
        do_pop |-> ((rd_ptr != wr_ptr) || (count == IQUEUE_DEPTH))
    );

endmodule

// ==== source/redirect_ctrl.sv ====
// Jump and context switch control
`timescale 1ns/100ps

module redirect_ctrl (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  sys_reset_i,
    input  logic                  jump_i,
    input  logic                  ctx_switch_i,
    input  fetch_addr_pkg::addr_t jump_target_i,
    input  fetch_addr_pkg::addr_t ctx_switch_target_i,
    input  logic                  accept_i,
    output logic                  redirect_o,
    output fetch_addr_pkg::addr_t redirect_target_o,
    output logic                  confirmed_r_o,
    output logic                  jumped_r_o,
    output fetch_addr_pkg::addr_t pc_target_o
);
    import fetch_addr_pkg::*;

    // Either request redirects the fetch stream
    assign redirect_o = jump_i || ctx_switch_i;

    // Context switch wins over a jump in the same cycle
    assign redirect_target_o = ctx_switch_i ? ctx_switch_target_i : jump_target_i;

    // Memory word returned in the next cycle belongs to the old stream
    // Starts high so the very first fetch is thrown away
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumped_r_o <= 1'b1;
        end else if (sys_reset_i) begin
            jumped_r_o <= 1'b1;
        end else begin
            jumped_r_o <= redirect_o;
        end
    end

    // Pending redirect, held until decode takes the first new instruction
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            confirmed_r_o <= 1'b1;
        end else if (sys_reset_i) begin
            confirmed_r_o <= 1'b1;
        end else if (redirect_o) begin
            confirmed_r_o <= 1'b1;
        end else if (accept_i) begin
            confirmed_r_o <= 1'b0;
        end
    end

    // Program counter that decode reports after the redirect
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_target_o <= START_ADDRESS;
        end else if (sys_reset_i) begin
            pc_target_o <= START_ADDRESS;
        end else if (redirect_o) begin
            pc_target_o <= redirect_target_o;
        end
    end

    // In-flight fetch must always be dropped after a redirect
    a_drop_after_redirect : assert property (
        @(posedge clk) disable iff (!reset_n)
        redirect_o |=> (jumped_r_o && !accept_i)
    );

endmodule
